//--- project.f
src/umi_pkg.sv
src/umi_split.sv
src/umi_async_fifo.sv
src/umi_fifo_flex.sv
tb/tb_umi_fifo_flex.sv

//--- run.sh
#!/bin/sh
# Compile and run the UMI FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
   --top-module tb_umi_fifo_flex -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

output=$(./obj_dir/Vtb_umi_fifo_flex)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1

//--- tb/tb_umi_fifo_flex.sv
/*
 * Testbench for the UMI width-changing FIFO.
 * Drives a table of wide transactions into the input side and predicts
 * the output-width pieces with a reference split model. A monitor on the
 * output clock compares every delivered beat against the expected queue
 * while the output ready toggles at random.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_umi_fifo_flex;

   import umi_pkg::*;

   localparam int IN_PERIOD   = 10;
   localparam int OUT_PERIOD  = 14;
   localparam int NUM_ENTRIES = 8;
   localparam int TIMEOUT_NS  = NUM_ENTRIES * 8 * OUT_PERIOD * 20;

   typedef struct
   {
      umi_opcode_e         opcode;
      logic [2:0]          size;
      logic [7:0]          len;
      logic                eom;
      logic [UMI_AW-1:0]   dstaddr;
      logic [UMI_AW-1:0]   srcaddr;
      logic [UMI_IDW-1:0]  data;
      logic                chaos;
   } stim_t;

   logic           umi_in_clk = 1'b0;
   logic           umi_out_clk = 1'b0;
   logic           umi_in_nreset;
   logic           umi_out_nreset;
   logic           chaosmode;
   logic           umi_in_valid;
   umi_in_beat_t   umi_in_beat;
   logic           umi_in_ready;
   logic           umi_out_valid;
   umi_out_beat_t  umi_out_beat;
   logic           umi_out_ready;
   logic           fifo_full;
   logic           fifo_empty;

   stim_t          stim_table [NUM_ENTRIES];
   umi_out_beat_t  exp_q [$];
   umi_out_beat_t  exp_beat;
   int             errors = 0;
   int             exp_count = 0;
   int             rcv_count = 0;
   logic           seen_full = 1'b0;

   always #(IN_PERIOD / 2) umi_in_clk = ~umi_in_clk;
   always #(OUT_PERIOD / 2) umi_out_clk = ~umi_out_clk;

   umi_fifo_flex umi_fifo_flex_inst
     (
      .chaosmode      (chaosmode),
      .fifo_full      (fifo_full),
      .fifo_empty     (fifo_empty),
      .umi_in_clk     (umi_in_clk),
      .umi_in_nreset  (umi_in_nreset),
      .umi_in_valid   (umi_in_valid),
      .umi_in_beat    (umi_in_beat),
      .umi_in_ready   (umi_in_ready),
      .umi_out_clk    (umi_out_clk),
      .umi_out_nreset (umi_out_nreset),
      .umi_out_valid  (umi_out_valid),
      .umi_out_beat   (umi_out_beat),
      .umi_out_ready  (umi_out_ready)
      );

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   // Four 64-bit slices tagged with entry and slice number
   function automatic logic [UMI_IDW-1:0] make_data(input int tag);
      logic [UMI_IDW-1:0] d;
      int                 k;
      d = '0;
      for (k = 0; k < UMI_IDW / UMI_ODW; k++)
         d[k*UMI_ODW +: UMI_ODW] = {8'(tag), 8'(k), 48'h5a5a_c3c3_0f0f};
      return d;
   endfunction

   // Reference model of the split into output-width pieces
   task automatic predict_split(input umi_in_beat_t beat);
      umi_in_beat_t   rest;
      umi_out_beat_t  piece;
      int             words;
      int             per_beat;
      rest     = beat;
      per_beat = UMI_OBYTES >> beat.cmd.size;
      words    = int'(beat.cmd.len) + 1;
      while (words > per_beat)
      begin
         piece.cmd     = rest.cmd;
         piece.cmd.len = 8'(per_beat - 1);
         piece.cmd.eom = 1'b0;                   // Only the final piece keeps eom
         piece.dstaddr = rest.dstaddr;
         piece.srcaddr = rest.srcaddr;
         piece.data    = rest.data[UMI_ODW-1:0];
         exp_q.push_back(piece);
         exp_count++;
         words        = words - per_beat;
         rest.dstaddr = rest.dstaddr + 64'd8;
         rest.srcaddr = rest.srcaddr + 64'd8;
         rest.data    = rest.data >> UMI_ODW;
      end
      piece.cmd     = rest.cmd;
      piece.cmd.len = 8'(words - 1);
      piece.dstaddr = rest.dstaddr;
      piece.srcaddr = rest.srcaddr;
      piece.data    = rest.data[UMI_ODW-1:0];
      exp_q.push_back(piece);
      exp_count++;
   endtask

   // Called 1 ns after a rising edge, returns at the same point
   task automatic drive_entry(input stim_t e);
      umi_in_beat_t beat;
      logic         accepted;
      beat            = '0;
      beat.cmd.hostid = 5'h13;
      beat.cmd.qos    = 4'h6;
      beat.cmd.opcode = e.opcode;
      beat.cmd.size   = e.size;
      beat.cmd.len    = e.len;
      beat.cmd.eom    = e.eom;
      beat.dstaddr    = e.dstaddr;
      beat.srcaddr    = e.srcaddr;
      beat.data       = e.data;
      predict_split(beat);
      chaosmode    = e.chaos;
      umi_in_beat  = beat;
      umi_in_valid = 1'b1;
      accepted     = 1'b0;
      while (!accepted)
      begin
         @(negedge umi_in_clk);
         accepted = umi_in_ready;                // Transfer on the next edge
         @(posedge umi_in_clk);
      end
      #1;
   endtask

   //############################################################
   // Monitors
   //############################################################
   always @(negedge umi_out_clk)
   begin
      if (umi_out_nreset && umi_out_valid && umi_out_ready)
      begin
         if (exp_q.size() == 0)
         begin
            errors++;
            $display("An output beat arrived at %0t ns with none expected", $time);
         end
         else
         begin
            exp_beat = exp_q.pop_front();
            check_value("cmd", 64'(umi_out_beat.cmd), 64'(exp_beat.cmd));
            check_value("dstaddr", umi_out_beat.dstaddr, exp_beat.dstaddr);
            check_value("srcaddr", umi_out_beat.srcaddr, exp_beat.srcaddr);
            check_value("data", umi_out_beat.data, exp_beat.data);
            rcv_count++;
         end
      end
   end

   // Real full only, chaos mode forces full by itself
   always @(negedge umi_in_clk)
   begin
      if (umi_in_nreset && !chaosmode && fifo_full)
         seen_full = 1'b1;
   end

   initial
   begin
      void'($urandom(85));
      forever
      begin
         @(posedge umi_out_clk);
         #1;
         umi_out_ready = 1'($urandom % 2);       // Random read back-pressure
      end
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("Timeout: the output did not deliver every expected beat in time");
      $display("Finished with errors");
      $finish;
   end

   //############################################################
   // Stimulus
   //############################################################
   initial
   begin
      umi_in_nreset  = 1'b0;
      umi_out_nreset = 1'b0;
      chaosmode      = 1'b0;
      umi_in_valid   = 1'b0;
      umi_in_beat    = '0;
      umi_out_ready  = 1'b0;

      // opcode, size, len, eom, dstaddr, srcaddr, data, chaos
      stim_table[0] = '{UMI_REQ_WRITE, 3'd0, 8'd7, 1'b1, 64'h1000, 64'h8000,
                        make_data(0), 1'b0};
      stim_table[1] = '{UMI_REQ_WRITE, 3'd0, 8'd31, 1'b1, 64'h2000, 64'h9000,
                        make_data(1), 1'b0};
      stim_table[2] = '{UMI_REQ_POSTED, 3'd3, 8'd3, 1'b1, 64'h3000, 64'ha000,
                        make_data(2), 1'b0};
      stim_table[3] = '{UMI_RESP_READ, 3'd2, 8'd5, 1'b1, 64'h4000, 64'hb000,
                        make_data(3), 1'b0};
      stim_table[4] = '{UMI_REQ_WRITE, 3'd0, 8'd31, 1'b1, 64'h1_0ff8, 64'hc000,
                        make_data(4), 1'b1};
      stim_table[5] = '{UMI_REQ_POSTED, 3'd3, 8'd3, 1'b0, 64'h5000, 64'hd000,
                        make_data(5), 1'b1};
      stim_table[6] = '{UMI_REQ_READ, 3'd1, 8'd0, 1'b1, 64'h6000, 64'he000,
                        make_data(6), 1'b1};
      stim_table[7] = '{UMI_REQ_WRITE, 3'd1, 8'd15, 1'b1, 64'h7000, 64'hf000,
                        make_data(7), 1'b1};

      fork
         begin
            repeat (4) @(posedge umi_in_clk);
            #1 umi_in_nreset = 1'b1;
            @(negedge umi_in_clk);
            check_value("umi_in_ready after reset", 64'(umi_in_ready), 64'd0);
            check_value("umi_out_valid after reset", 64'(umi_out_valid), 64'd0);
            check_value("fifo_empty after reset", 64'(fifo_empty), 64'd1);
         end
         begin
            repeat (4) @(posedge umi_out_clk);
            #1 umi_out_nreset = 1'b1;
         end
      join

      wait (umi_in_ready == 1'b1);               // Start-up gating done
      @(posedge umi_in_clk);
      #1;
      for (int i = 0; i < NUM_ENTRIES; i++)
         drive_entry(stim_table[i]);
      umi_in_valid = 1'b0;
      chaosmode    = 1'b0;

      wait (rcv_count == exp_count);
      repeat (10) @(posedge umi_out_clk);        // Room for any extra beat
      @(negedge umi_out_clk);
      check_value("fifo_empty at end", 64'(fifo_empty), 64'd1);
      check_value("beats still pending", 64'(exp_q.size()), 64'd0);
      check_value("fifo_full seen", 64'(seen_full), 64'd1);

      $display("Beats checked %0d of %0d, errors %0d", rcv_count, exp_count, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- src/umi_fifo_flex.sv
/*
 * Top level of the UMI width-changing FIFO.
 * Wide transactions enter on the umi_in_clk side, are split into
 * output-width pieces and cross to the umi_out_clk side through a
 * dual-clock FIFO. chaosmode adds random write back-pressure.
 */

`timescale 1ns/1ns
`default_nettype none

module umi_fifo_flex
  (
   // Control and status
   input  wire                     chaosmode,
   output logic                    fifo_full,
   output logic                    fifo_empty,
   // Input side
   input  wire                     umi_in_clk,
   input  wire                     umi_in_nreset,
   input  wire                     umi_in_valid,
   input  umi_pkg::umi_in_beat_t   umi_in_beat,
   output logic                    umi_in_ready,
   // Output side
   input  wire                     umi_out_clk,
   input  wire                     umi_out_nreset,
   output logic                    umi_out_valid,
   output umi_pkg::umi_out_beat_t  umi_out_beat,
   input  wire                     umi_out_ready
   );

   import umi_pkg::*;

   logic           wr_en;
   umi_out_beat_t  wr_beat;
   logic           wr_full;
   logic           rd_empty;

   //###########################################################
   // Splitter
   //###########################################################
   umi_split umi_split_inst
     (
      .umi_in_clk     (umi_in_clk),
      .umi_in_nreset  (umi_in_nreset),
      .umi_in_valid   (umi_in_valid),
      .umi_in_beat    (umi_in_beat),
      .umi_in_ready   (umi_in_ready),
      .wr_en          (wr_en),
      .wr_beat        (wr_beat),
      .wr_full        (wr_full)
      );

   //###########################################################
   // Clock crossing
   //###########################################################
   umi_async_fifo umi_async_fifo_inst
     (
      .umi_in_clk     (umi_in_clk),
      .umi_in_nreset  (umi_in_nreset),
      .wr_en          (wr_en),
      .wr_beat        (wr_beat),
      .chaosmode      (chaosmode),
      .wr_full        (wr_full),
      .umi_out_clk    (umi_out_clk),
      .umi_out_nreset (umi_out_nreset),
      .rd_en          (umi_out_ready),                        // Ignored while empty
      .rd_beat        (umi_out_beat),
      .rd_empty       (rd_empty)
      );

   assign umi_out_valid = ~rd_empty;
   assign fifo_full     = wr_full;                            // Includes chaos pushback
   assign fifo_empty    = rd_empty;

endmodule

`default_nettype wire

//--- src/umi_async_fifo.sv
/*
 * Dual-clock FIFO carrying output-width UMI beats.
 * Write side runs on umi_in_clk, read side on umi_out_clk. Pointers cross
 * as Gray code through two-flop synchronizers, so full and empty are
 * conservative. In chaos mode an LFSR forces full on about half the write
 * cycles to stress the upstream back-pressure path.
 */

`timescale 1ns/1ns
`default_nettype none

module umi_async_fifo
  (
   // Write side
   input  wire                     umi_in_clk,
   input  wire                     umi_in_nreset,
   input  wire                     wr_en,
   input  umi_pkg::umi_out_beat_t  wr_beat,
   input  wire                     chaosmode,
   output logic                    wr_full,
   // Read side
   input  wire                     umi_out_clk,
   input  wire                     umi_out_nreset,
   input  wire                     rd_en,
   output umi_pkg::umi_out_beat_t  rd_beat,
   output logic                    rd_empty
   );

   import umi_pkg::*;

   umi_out_beat_t      mem [FIFO_DEPTH];

   logic [FIFO_AW:0]   wr_bin;
   logic [FIFO_AW:0]   wr_bin_next;
   logic [FIFO_AW:0]   wr_gray;
   logic [FIFO_AW:0]   rd_gray_s1;
   logic [FIFO_AW:0]   rd_gray_s2;
   logic               full_real;
   logic               wr_push;
   logic [7:0]         lfsr;

   logic [FIFO_AW:0]   rd_bin;
   logic [FIFO_AW:0]   rd_bin_next;
   logic [FIFO_AW:0]   rd_gray;
   logic [FIFO_AW:0]   wr_gray_s1;
   logic [FIFO_AW:0]   wr_gray_s2;
   logic               rd_pop;

   //###########################################################
   // Write domain
   //###########################################################
   assign wr_bin_next = wr_bin + 1'b1;
   assign wr_push     = wr_en & ~full_real;

   // Full when pointers differ only in the two top Gray bits
   assign full_real = (wr_gray == {~rd_gray_s2[FIFO_AW:FIFO_AW-1],
                                   rd_gray_s2[FIFO_AW-2:0]});

   assign wr_full = full_real | (chaosmode & lfsr[0]);

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
      begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
      end
      else
      begin
         rd_gray_s1 <= rd_gray;                               // Read pointer crossing
         rd_gray_s2 <= rd_gray_s1;
         if (wr_push)
         begin
            wr_bin  <= wr_bin_next;
            wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
         end
      end
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (wr_push)
         mem[wr_bin[FIFO_AW-1:0]] <= wr_beat;
   end

   // x^8 + x^6 + x^5 + x^4 + 1, free running
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         lfsr <= 8'hA5;
      else
         lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
   end

   //###########################################################
   // Read domain
   //###########################################################
   assign rd_bin_next = rd_bin + 1'b1;
   assign rd_empty    = (rd_gray == wr_gray_s2);
   assign rd_pop      = rd_en & ~rd_empty;
   assign rd_beat     = mem[rd_bin[FIFO_AW-1:0]];            // Head entry

   always_ff @(posedge umi_out_clk or negedge umi_out_nreset)
   begin
      if (!umi_out_nreset)
      begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
      end
      else
      begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
         if (rd_pop)
         begin
            rd_bin  <= rd_bin_next;
            rd_gray <= rd_bin_next ^ (rd_bin_next >> 1);
         end
      end
   end

   // A pop only takes an entry the write side has really written
   a_no_read_when_empty: assert property
     (@(posedge umi_out_clk) disable iff (!umi_out_nreset)
      rd_pop |-> (rd_gray != wr_gray));

endmodule

`default_nettype wire

//--- src/umi_split.sv
/*
 * Input-side splitter for the UMI width-changing FIFO.
 * Takes wide transactions on the input bus and writes one output-width
 * beat per FIFO write. Oversize transactions are latched and the remainder
 * is sent on following write cycles with its own command, advanced
 * addresses and shifted data. Input is held off while a remainder is kept.
 */

`timescale 1ns/1ns
`default_nettype none

module umi_split
  (
   input  wire                     umi_in_clk,
   input  wire                     umi_in_nreset,
   input  wire                     umi_in_valid,
   input  umi_pkg::umi_in_beat_t   umi_in_beat,
   output logic                    umi_in_ready,
   output logic                    wr_en,
   output umi_pkg::umi_out_beat_t  wr_beat,
   input  wire                     wr_full
   );

   import umi_pkg::*;

   logic [1:0]    start_sr;   // Start-up delay after reset
   logic          started;
   logic          rem_valid;  // Remainder held in rem_beat
   umi_in_beat_t  rem_beat;
   umi_in_beat_t  src_beat;
   umi_in_beat_t  rem_next;
   umi_cmd_t      out_cmd;
   logic [8:0]    len_p1;
   logic [8:0]    cap;
   logic          split;

   //###########################################################
   // Start-up gating
   //###########################################################
   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         start_sr <= 2'b00;
      else
         start_sr <= {start_sr[0], 1'b1};
   end

   assign started = start_sr[1];

   //###########################################################
   // Split rule
   //###########################################################
   assign src_beat = rem_valid ? rem_beat : umi_in_beat;

   assign len_p1 = {1'b0, src_beat.cmd.len} + 9'd1;           // Word count
   assign cap    = 9'(UMI_OBYTES >> src_beat.cmd.size);      // Words per beat
   assign split  = (len_p1 > cap);

   always_comb
   begin
      out_cmd = src_beat.cmd;
      if (split)
      begin
         out_cmd.len = 8'(cap - 9'd1);
         out_cmd.eom = 1'b0;                                  // Not the last piece
      end
   end

   // What is left after this beat goes out
   always_comb
   begin
      rem_next         = src_beat;
      rem_next.cmd.len = 8'(len_p1 - cap - 9'd1);
      rem_next.dstaddr = src_beat.dstaddr + UMI_AW'(UMI_OBYTES);
      rem_next.srcaddr = src_beat.srcaddr + UMI_AW'(UMI_OBYTES);
      rem_next.data    = src_beat.data >> UMI_ODW;
   end

   assign wr_beat = '{cmd:     out_cmd,
                      dstaddr: src_beat.dstaddr,
                      srcaddr: src_beat.srcaddr,
                      data:    src_beat.data[UMI_ODW-1:0]};

   //###########################################################
   // Handshake and remainder latch
   //###########################################################
   assign wr_en        = started & ~wr_full & (rem_valid | umi_in_valid);
   assign umi_in_ready = started & ~wr_full & ~rem_valid;

   always_ff @(posedge umi_in_clk or negedge umi_in_nreset)
   begin
      if (!umi_in_nreset)
         rem_valid <= 1'b0;
      else if (wr_en)
         rem_valid <= split;                                  // Cleared on final piece
   end

   always_ff @(posedge umi_in_clk)
   begin
      if (wr_en && split)
         rem_beat <= rem_next;
   end

   // Input stays closed on the cycle after any split write
   a_ready_low_on_remainder: assert property
     (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      (wr_en && split) |=> !umi_in_ready);

   // Full FIFO, real or chaos, leaves the latched remainder untouched
   a_hold_on_full: assert property
     (@(posedge umi_in_clk) disable iff (!umi_in_nreset)
      (rem_valid && wr_full) |=> (rem_valid && $stable(rem_beat)));

endmodule

`default_nettype wire

//--- src/umi_pkg.sv
/*
 * Shared definitions for the UMI width-changing FIFO.
 * Holds the bus widths, the FIFO depth, the UMI opcode encoding and the
 * packed command and beat structs. Modules pull these in with a wildcard
 * import in the body and use scoped names in their port lists.
 */

`default_nettype none

package umi_pkg;

   //###########################################################
   // Bus widths and FIFO geometry
   //###########################################################
   localparam int UMI_CW     = 32;  // Command word
   localparam int UMI_AW     = 64;  // Address
   localparam int UMI_IDW    = 256; // Input data bus
   localparam int UMI_ODW    = 64;  // Output data bus
   localparam int UMI_OBYTES = UMI_ODW / 8;

   localparam int FIFO_DEPTH = 4;   // Must stay a power of two
   localparam int FIFO_AW    = 2;   // log2(FIFO_DEPTH)

   //###########################################################
   // Command encoding
   //###########################################################
   typedef enum logic [4:0]
   {
      UMI_INVALID    = 5'h00,
      UMI_REQ_READ   = 5'h01,
      UMI_RESP_READ  = 5'h02,
      UMI_REQ_WRITE  = 5'h03,
      UMI_RESP_WRITE = 5'h04,
      UMI_REQ_POSTED = 5'h05
   } umi_opcode_e;

   // Field order is MSB first
   typedef struct packed
   {
      logic [4:0]  hostid;
      logic [1:0]  user;
      logic        ex;
      logic        eof;
      logic        eom;      // End of message, last piece only
      logic [1:0]  prot;
      logic [3:0]  qos;
      logic [7:0]  len;      // Words minus one
      logic [2:0]  size;     // log2 of word size in bytes
      umi_opcode_e opcode;
   } umi_cmd_t;

   typedef struct packed
   {
      umi_cmd_t             cmd;
      logic [UMI_AW-1:0]    dstaddr;
      logic [UMI_AW-1:0]    srcaddr;
      logic [UMI_IDW-1:0]   data;
   } umi_in_beat_t;

   typedef struct packed
   {
      umi_cmd_t             cmd;
      logic [UMI_AW-1:0]    dstaddr;
      logic [UMI_AW-1:0]    srcaddr;
      logic [UMI_ODW-1:0]   data;
   } umi_out_beat_t;

endpackage

`default_nettype wire
